/* all.f */
+incdir+hw
hw/axi_mem_pkg.sv
hw/sync_fifo.sv
hw/axi_rd_burst.sv
hw/axi_wr_burst.sv
hw/rw_arbiter.sv
hw/mem_port.sv
hw/resp_tracker.sv
hw/axi_mem_top.sv
sim/axi_mem_sva.sv
sim/tb_axi_mem.sv

/* hw/axi_mem_consts.svh */
// Width and depth constants of the banked AXI memory slave, included by the package and RTL
`ifndef AXI_MEM_CONSTS_SVH
`define AXI_MEM_CONSTS_SVH

// AXI side
`define AXI_MEM_ADDR_WIDTH 16
`define AXI_MEM_DATA_WIDTH 32
`define AXI_MEM_ID_WIDTH   4
`define AXI_MEM_LEN_WIDTH  8
`define AXI_MEM_SIZE_WIDTH 3  // log2 of bytes per beat

// Memory side
`define AXI_MEM_NUM_BANKS  2
`define AXI_MEM_BUF_DEPTH  2  // Requests in flight and FIFO depth

`endif

/* hw/axi_mem_pkg.sv */
// Channel, metadata and memory request types shared by all blocks of the AXI memory slave
`include "axi_mem_consts.svh"

package axi_mem_pkg;

  typedef logic [`AXI_MEM_ADDR_WIDTH-1:0]                      addr_t;
  typedef logic [`AXI_MEM_DATA_WIDTH-1:0]                      data_t;
  typedef logic [`AXI_MEM_DATA_WIDTH/8-1:0]                    strb_t;
  typedef logic [`AXI_MEM_ID_WIDTH-1:0]                        id_t;
  typedef logic [`AXI_MEM_LEN_WIDTH-1:0]                       len_t;
  typedef logic [`AXI_MEM_SIZE_WIDTH-1:0]                      size_t;
  typedef logic [`AXI_MEM_DATA_WIDTH/`AXI_MEM_NUM_BANKS-1:0]   bank_data_t;
  typedef logic [`AXI_MEM_DATA_WIDTH/`AXI_MEM_NUM_BANKS/8-1:0] bank_strb_t;

  // AR and AW, INCR bursts only
  typedef struct packed {
    addr_t addr;
    id_t   id;
    len_t  len;
    size_t size;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  // Responses are always OKAY so no resp field
  typedef struct packed {
    data_t data;
    id_t   id;
    logic  last;
  } r_chan_t;

  typedef struct packed {
    id_t id;
  } b_chan_t;

  // One entry per issued beat, waits for the memory response
  typedef struct packed {
    addr_t addr;
    id_t   id;
    logic  last;
    logic  write;
  } meta_t;

  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t strb;
    logic  we;
  } mem_req_t;

  typedef struct packed {
    addr_t      addr;   // Byte address of the bank slice
    bank_data_t wdata;
    bank_strb_t strb;
    logic       we;
  } bank_req_t;

  typedef enum logic {
    SEL_READ  = 1'b0,
    SEL_WRITE = 1'b1
  } arb_sel_e;

endpackage

/* hw/axi_mem_top.sv */
// AXI memory slave top level, connects burst generators, arbiter, bank port and response tracker
`include "axi_mem_consts.svh"

module axi_mem_top import axi_mem_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  output logic                                busy_o,
  input  logic                                ar_valid_i,
  output logic                                ar_ready_o,
  input  ax_chan_t                            ar_i,
  input  logic                                aw_valid_i,
  output logic                                aw_ready_o,
  input  ax_chan_t                            aw_i,
  input  logic                                w_valid_i,
  output logic                                w_ready_o,
  input  w_chan_t                             w_i,
  output logic                                r_valid_o,
  input  logic                                r_ready_i,
  output r_chan_t                             r_o,
  output logic                                b_valid_o,
  input  logic                                b_ready_i,
  output b_chan_t                             b_o,
  output logic       [`AXI_MEM_NUM_BANKS-1:0] bank_req_o,
  output bank_req_t  [`AXI_MEM_NUM_BANKS-1:0] bank_o,
  input  logic       [`AXI_MEM_NUM_BANKS-1:0] bank_gnt_i,
  input  logic       [`AXI_MEM_NUM_BANKS-1:0] bank_rvalid_i,
  input  bank_data_t [`AXI_MEM_NUM_BANKS-1:0] bank_rdata_i
);

  logic     rd_valid, rd_in_burst, rd_take;
  logic     wr_valid, wr_in_burst, wr_take;
  meta_t    rd_beat, wr_beat, meta;
  mem_req_t mem_req;
  logic     issue, meta_room, mem_ready;
  logic     resp_valid, resp_pop;
  data_t    resp_data;

  assign busy_o = ar_valid_i | aw_valid_i | w_valid_i | r_valid_o | b_valid_o |
                  rd_in_burst | wr_in_burst;

  axi_rd_burst u_rd_burst (
    .clk_i, .rst_ni, .ar_valid_i, .ar_ready_o, .ar_i,
    .beat_valid_o (rd_valid),
    .beat_o       (rd_beat),
    .take_i       (rd_take),
    .in_burst_o   (rd_in_burst)
  );

  axi_wr_burst u_wr_burst (
    .clk_i, .rst_ni, .aw_valid_i, .aw_ready_o, .aw_i, .w_valid_i, .w_ready_o,
    .beat_valid_o (wr_valid),
    .beat_o       (wr_beat),
    .take_i       (wr_take),
    .in_burst_o   (wr_in_burst)
  );

  rw_arbiter u_arbiter (
    .clk_i, .rst_ni, .w_i,
    .rd_valid_i    (rd_valid),
    .rd_beat_i     (rd_beat),
    .rd_in_burst_i (rd_in_burst),
    .wr_valid_i    (wr_valid),
    .wr_beat_i     (wr_beat),
    .wr_in_burst_i (wr_in_burst),
    .meta_room_i   (meta_room),
    .mem_ready_i   (mem_ready),
    .rd_take_o     (rd_take),
    .wr_take_o     (wr_take),
    .issue_o       (issue),
    .meta_o        (meta),
    .mem_req_o     (mem_req)
  );

  mem_port u_mem_port (
    .clk_i, .rst_ni, .bank_req_o, .bank_o, .bank_gnt_i, .bank_rvalid_i, .bank_rdata_i,
    .issue_i      (issue),
    .req_i        (mem_req),
    .mem_ready_o  (mem_ready),
    .resp_valid_o (resp_valid),
    .resp_data_o  (resp_data),
    .resp_pop_i   (resp_pop)
  );

  resp_tracker u_resp_tracker (
    .clk_i, .rst_ni, .r_valid_o, .r_ready_i, .r_o, .b_valid_o, .b_ready_i, .b_o,
    .issue_i      (issue),
    .meta_i       (meta),
    .meta_room_o  (meta_room),
    .resp_valid_i (resp_valid),
    .resp_data_i  (resp_data),
    .resp_pop_o   (resp_pop)
  );

endmodule

/* hw/axi_rd_burst.sv */
// Read burst address generator, turns one AR into a stream of beat metadata for the arbiter
module axi_rd_burst import axi_mem_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     ar_valid_i,
  output logic     ar_ready_o,
  input  ax_chan_t ar_i,
  output logic     beat_valid_o,
  output meta_t    beat_o,
  input  logic     take_i,
  output logic     in_burst_o
);

  len_t  cnt_q, cnt_d;   // Beats left after the current one
  addr_t addr_q, addr_d; // Aligned address of the last issued beat
  addr_t next_addr;
  id_t   id_q;
  size_t size_q;

  assign next_addr  = addr_q + (addr_t'(1) << size_q);
  assign in_burst_o = (cnt_q != '0);

  always_comb begin
    ar_ready_o   = 1'b0;
    beat_valid_o = 1'b0;
    beat_o       = '{addr: next_addr, id: id_q, last: (cnt_q == len_t'(1)), write: 1'b0};
    cnt_d        = cnt_q;
    addr_d       = addr_q;
    if (in_burst_o) begin
      beat_valid_o = 1'b1;
      if (take_i) begin
        cnt_d  = cnt_q - len_t'(1);
        addr_d = next_addr;
      end
    end else if (ar_valid_i) begin
      // First beat keeps the unaligned address
      beat_valid_o = 1'b1;
      beat_o       = '{addr: ar_i.addr, id: ar_i.id, last: (ar_i.len == '0), write: 1'b0};
      if (take_i) begin
        ar_ready_o = 1'b1;
        cnt_d      = ar_i.len;
        addr_d     = ar_i.addr & ~((addr_t'(1) << ar_i.size) - addr_t'(1));
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    if (ar_ready_o) begin
      id_q   <= ar_i.id;
      size_q <= ar_i.size;
    end
  end

endmodule

/* hw/axi_wr_burst.sv */
// Write burst address generator, pairs AW with W beats and offers one beat at a time
module axi_wr_burst import axi_mem_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     aw_valid_i,
  output logic     aw_ready_o,
  input  ax_chan_t aw_i,
  input  logic     w_valid_i,
  output logic     w_ready_o,
  output logic     beat_valid_o,
  output meta_t    beat_o,
  input  logic     take_i,
  output logic     in_burst_o
);

  len_t  cnt_q, cnt_d;
  addr_t addr_q, addr_d;
  addr_t next_addr;
  id_t   id_q;
  size_t size_q;

  assign next_addr  = addr_q + (addr_t'(1) << size_q);
  assign in_burst_o = (cnt_q != '0);

  always_comb begin
    aw_ready_o   = 1'b0;
    w_ready_o    = 1'b0;
    beat_valid_o = 1'b0;
    beat_o       = '{addr: next_addr, id: id_q, last: (cnt_q == len_t'(1)), write: 1'b1};
    cnt_d        = cnt_q;
    addr_d       = addr_q;
    if (in_burst_o) begin
      beat_valid_o = w_valid_i;  // Paced by W
      if (w_valid_i && take_i) begin
        w_ready_o = 1'b1;
        cnt_d     = cnt_q - len_t'(1);
        addr_d    = next_addr;
      end
    end else if (aw_valid_i && w_valid_i) begin
      beat_valid_o = 1'b1;
      beat_o       = '{addr: aw_i.addr, id: aw_i.id, last: (aw_i.len == '0), write: 1'b1};
      if (take_i) begin
        aw_ready_o = 1'b1;
        w_ready_o  = 1'b1;
        cnt_d      = aw_i.len;
        addr_d     = aw_i.addr & ~((addr_t'(1) << aw_i.size) - addr_t'(1));
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    if (aw_ready_o) begin
      id_q   <= aw_i.id;
      size_q <= aw_i.size;
    end
  end

endmodule

/* hw/mem_port.sv */
// Banked memory port, splits each request over the banks and reassembles the answers in order
`include "axi_mem_consts.svh"

module mem_port import axi_mem_pkg::*; (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  issue_i,
  input  mem_req_t                              req_i,
  output logic                                  mem_ready_o,
  output logic       [`AXI_MEM_NUM_BANKS-1:0]   bank_req_o,
  output bank_req_t  [`AXI_MEM_NUM_BANKS-1:0]   bank_o,
  input  logic       [`AXI_MEM_NUM_BANKS-1:0]   bank_gnt_i,
  input  logic       [`AXI_MEM_NUM_BANKS-1:0]   bank_rvalid_i,
  input  bank_data_t [`AXI_MEM_NUM_BANKS-1:0]   bank_rdata_i,
  output logic                                  resp_valid_o,
  output data_t                                 resp_data_o,
  input  logic                                  resp_pop_i
);

  localparam int unsigned NUM_BANKS   = `AXI_MEM_NUM_BANKS;
  localparam int unsigned BUF_DEPTH   = `AXI_MEM_BUF_DEPTH;
  localparam int unsigned BANK_BYTES  = `AXI_MEM_DATA_WIDTH / 8 / NUM_BANKS;
  localparam int unsigned BANK_BITS   = 8 * BANK_BYTES;
  localparam int unsigned WORD_OFFSET = $clog2(`AXI_MEM_DATA_WIDTH / 8);
  localparam int unsigned CNT_WIDTH   = $clog2(BUF_DEPTH + 1);

  logic [CNT_WIDTH-1:0]  cnt_q;       // Issued, response not yet popped
  logic [NUM_BANKS-1:0]  hold_valid_q, rsp_valid_q, have;
  bank_req_t             hold_q [NUM_BANKS];
  bank_data_t            rsp_q  [NUM_BANKS];
  bank_req_t             new_req [NUM_BANKS];
  addr_t                 word_addr;
  data_t                 word;
  logic                  word_done, resp_empty;

  assign word_addr = (req_i.addr >> WORD_OFFSET) << WORD_OFFSET;

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    assign new_req[i] = '{
      addr:  word_addr + addr_t'(i * BANK_BYTES),
      wdata: req_i.wdata[i*BANK_BITS +: BANK_BITS],
      strb:  req_i.strb[i*BANK_BYTES +: BANK_BYTES],
      we:    req_i.we
    };
    assign bank_req_o[i] = hold_valid_q[i] | issue_i;  // Fall-through
    assign bank_o[i]     = hold_valid_q[i] ? hold_q[i] : new_req[i];
    assign have[i]       = rsp_valid_q[i] | bank_rvalid_i[i];
  end

  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      word[i*BANK_BITS +: BANK_BITS] = rsp_valid_q[i] ? rsp_q[i] : bank_rdata_i[i];
    end
  end

  assign word_done = &have;

  // A partial answer also blocks issue so no bank can run a word ahead
  assign mem_ready_o = (cnt_q != CNT_WIDTH'(BUF_DEPTH)) && !(|hold_valid_q) && !(|rsp_valid_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q        <= '0;
      hold_valid_q <= '0;
      rsp_valid_q  <= '0;
    end else begin
      if (issue_i && !resp_pop_i) begin
        cnt_q <= cnt_q + CNT_WIDTH'(1);
      end else if (resp_pop_i && !issue_i) begin
        cnt_q <= cnt_q - CNT_WIDTH'(1);
      end
      hold_valid_q <= bank_req_o & ~bank_gnt_i;
      rsp_valid_q  <= word_done ? '0 : have;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (!hold_valid_q[i]) begin
        hold_q[i] <= new_req[i];
      end
      if (bank_rvalid_i[i]) begin
        rsp_q[i] <= bank_rdata_i[i];
      end
    end
  end

  // Never overflows, cnt_q caps the words in flight at the depth
  sync_fifo #(
    .DEPTH (BUF_DEPTH),
    .WIDTH (`AXI_MEM_DATA_WIDTH)
  ) u_resp_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (word_done),
    .data_i  (word),
    .pop_i   (resp_pop_i),
    .full_o  (),
    .empty_o (resp_empty),
    .data_o  (resp_data_o)
  );

  assign resp_valid_o = !resp_empty;

endmodule

/* hw/resp_tracker.sv */
// Response tracker, pairs beat metadata with memory words and routes them to R or B
`include "axi_mem_consts.svh"

module resp_tracker import axi_mem_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    issue_i,
  input  meta_t   meta_i,
  output logic    meta_room_o,
  input  logic    resp_valid_i,
  input  data_t   resp_data_i,
  output logic    resp_pop_o,
  output logic    r_valid_o,
  input  logic    r_ready_i,
  output r_chan_t r_o,
  output logic    b_valid_o,
  input  logic    b_ready_i,
  output b_chan_t b_o
);

  meta_t head;
  logic  meta_full, meta_empty;
  logic  both;

  sync_fifo #(
    .DEPTH (`AXI_MEM_BUF_DEPTH),
    .WIDTH ($bits(meta_t))
  ) u_meta_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (issue_i),
    .data_i  (meta_i),
    .pop_i   (resp_pop_o),
    .full_o  (meta_full),
    .empty_o (meta_empty),
    .data_o  (head)
  );

  assign meta_room_o = !meta_full;
  assign both        = resp_valid_i && !meta_empty;

  assign r_valid_o = both && !head.write;
  assign b_valid_o = both && head.write && head.last;

  // Writes that are not the last beat vanish here
  assign resp_pop_o = (r_valid_o && r_ready_i) || (b_valid_o && b_ready_i) ||
                      (both && head.write && !head.last);

  assign r_o = '{data: resp_data_i, id: head.id, last: head.last};
  assign b_o = '{id: head.id};

endmodule

/* hw/rw_arbiter.sv */
// Read/write beat arbiter, picks one beat per issue and forms the memory request from it
module rw_arbiter import axi_mem_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     rd_valid_i,
  input  meta_t    rd_beat_i,
  input  logic     rd_in_burst_i,
  input  logic     wr_valid_i,
  input  meta_t    wr_beat_i,
  input  logic     wr_in_burst_i,
  input  w_chan_t  w_i,
  input  logic     meta_room_i,
  input  logic     mem_ready_i,
  output logic     rd_take_o,
  output logic     wr_take_o,
  output logic     issue_o,
  output meta_t    meta_o,
  output mem_req_t mem_req_o
);

  arb_sel_e sel_q, sel_d;
  logic     lock_q, lock_d;
  logic     arb_valid;
  logic     room;

  assign room = meta_room_i & mem_ready_i;

  always_comb begin
    sel_d = sel_q;
    if (lock_q) begin
      sel_d = sel_q;  // Held until the chosen beat issues
    end else if (wr_valid_i && !rd_valid_i) begin
      sel_d = SEL_WRITE;
    end else if (rd_valid_i && !wr_valid_i) begin
      sel_d = SEL_READ;
    end else if (wr_valid_i && rd_valid_i) begin
      if (wr_beat_i.last && !rd_beat_i.last) begin
        sel_d = SEL_WRITE;  // Single write goes before a read burst
      end else if (wr_in_burst_i) begin
        sel_d = SEL_WRITE;  // Write bursts cannot interleave
      end else if (rd_in_burst_i) begin
        sel_d = SEL_READ;
      end else begin
        sel_d = (sel_q == SEL_READ) ? SEL_WRITE : SEL_READ;
      end
    end
  end

  assign arb_valid = (sel_d == SEL_WRITE) ? wr_valid_i : rd_valid_i;
  assign issue_o   = arb_valid & room;
  assign rd_take_o = issue_o & (sel_d == SEL_READ);
  assign wr_take_o = issue_o & (sel_d == SEL_WRITE);
  assign meta_o    = (sel_d == SEL_WRITE) ? wr_beat_i : rd_beat_i;

  // W payload only matters for writes
  assign mem_req_o = '{
    addr:  meta_o.addr,
    wdata: w_i.data,
    strb:  meta_o.write ? w_i.strb : '0,
    we:    meta_o.write
  };

  assign lock_d = lock_q ? !issue_o : (arb_valid && !room);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q  <= SEL_READ;
      lock_q <= 1'b0;
    end else begin
      sel_q  <= sel_d;
      lock_q <= lock_d;
    end
  end

endmodule

/* hw/sync_fifo.sv */
// Fall-through ring buffer FIFO, holds metadata and memory responses in the AXI memory slave
module sync_fifo #(
  parameter int unsigned DEPTH = 2,
  parameter int unsigned WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic             full_o,
  output logic             empty_o,
  output logic [WIDTH-1:0] data_o
);

  localparam int unsigned PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_WIDTH = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]     mem_q [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_WIDTH-1:0] cnt_q;
  logic                 bypass, do_push, do_pop;

  assign full_o  = (cnt_q == CNT_WIDTH'(DEPTH));
  assign empty_o = (cnt_q == '0) && !push_i;
  assign data_o  = (cnt_q == '0) ? data_i : mem_q[rd_ptr_q];

  // Word pushed into an empty FIFO and popped at once never gets stored
  assign bypass  = (cnt_q == '0) && push_i && pop_i;
  assign do_push = push_i && !full_o && !bypass;
  assign do_pop  = pop_i && (cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_WIDTH'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_WIDTH'(1);
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + CNT_WIDTH'(1);
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - CNT_WIDTH'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

/* sim/axi_mem_sva.sv */
// Protocol assertions for the AXI memory slave, bound into the top level by the bind below
`include "axi_mem_consts.svh"

module axi_mem_sva import axi_mem_pkg::*; (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          ar_valid_i,
  input logic                          ar_ready_i,
  input logic                          aw_valid_i,
  input logic                          aw_ready_i,
  input logic                          r_valid_i,
  input logic                          r_ready_i,
  input r_chan_t                       r_i,
  input logic                          b_valid_i,
  input logic                          b_ready_i,
  input b_chan_t                       b_i,
  input logic [`AXI_MEM_NUM_BANKS-1:0] bank_req_i
);

  int unsigned assert_fails = 0;  // Read by the testbench at the end

  r_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
    else begin
      $error("R channel changed while stalled");
      assert_fails++;
    end

  b_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_i))
    else begin
      $error("B channel changed while stalled");
      assert_fails++;
    end

  ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ar_ready_i && !ar_valid_i) && !(aw_ready_i && !aw_valid_i))
    else begin
      $error("Address ready raised without valid");
      assert_fails++;
    end

  // Bank side must stay quiet in reset
  no_req_in_reset: assert property (@(posedge clk_i) !rst_ni |-> (bank_req_i == '0))
    else begin
      $error("Bank request during reset");
      assert_fails++;
    end

endmodule

bind axi_mem_top axi_mem_sva u_axi_mem_sva (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .ar_valid_i (ar_valid_i),
  .ar_ready_i (ar_ready_o),
  .aw_valid_i (aw_valid_i),
  .aw_ready_i (aw_ready_o),
  .r_valid_i  (r_valid_o),
  .r_ready_i  (r_ready_i),
  .r_i        (r_o),
  .b_valid_i  (b_valid_o),
  .b_ready_i  (b_ready_i),
  .b_i        (b_o),
  .bank_req_i (bank_req_o)
);

/* sim/axi_mem_trace.txt */
# W id addr len first_data strb  (beat k writes first_data+k at addr+4k)
# R id addr len first_word  (beat k expects first_word+k), S waits until all bursts are done
W 1 0100 00 11223344 f
S
W 2 0100 00 aabbccdd 5
S
R 3 0100 00 11bb33dd
S
W 4 0200 07 a0000000 f
S
R 5 0200 07 a0000000
W 6 0400 03 c0000010 f
S
R 7 0400 03 c0000010
S

/* sim/tb_axi_mem.sv */
// Testbench for the AXI memory slave that runs the burst trace against a banked memory model
`include "axi_mem_consts.svh"

module tb_axi_mem import axi_mem_pkg::*; ();

  localparam int NB         = `AXI_MEM_NUM_BANKS;
  localparam int BANK_BYTES = `AXI_MEM_DATA_WIDTH / 8 / NB;
  localparam int MAX_LINES  = 64;

  logic clk_i, rst_ni, busy;
  logic ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
  logic r_valid, r_ready, b_valid, b_ready;
  ax_chan_t ar, aw;
  w_chan_t  w;
  r_chan_t  r;
  b_chan_t  b;
  logic       [NB-1:0] bank_req, bank_gnt, bank_rvalid;
  bank_req_t  [NB-1:0] bank;
  bank_data_t [NB-1:0] bank_rdata;

  logic [7:0]  bank_mem [NB][1 << `AXI_MEM_ADDR_WIDTH];
  int          wait_cnt [NB];  // Cycles until the bank grants again
  string       tr_op [MAX_LINES];
  logic [31:0] tr_id [MAX_LINES], tr_addr [MAX_LINES], tr_len [MAX_LINES];
  logic [31:0] tr_data [MAX_LINES], tr_strb [MAX_LINES];
  int          n_lines, total_beats, errors, r_beats, b_seen, writes_done;
  int unsigned cycles, cycle_limit;
  r_chan_t     exp_r [$];
  id_t         exp_b [$];
  r_chan_t     exp_beat;
  bit          trace_ok;

  axi_mem_top u_axi_mem_top (
    .clk_i, .rst_ni, .busy_o (busy),
    .ar_valid_i (ar_valid), .ar_ready_o (ar_ready), .ar_i (ar),
    .aw_valid_i (aw_valid), .aw_ready_o (aw_ready), .aw_i (aw),
    .w_valid_i (w_valid), .w_ready_o (w_ready), .w_i (w),
    .r_valid_o (r_valid), .r_ready_i (r_ready), .r_o (r),
    .b_valid_o (b_valid), .b_ready_i (b_ready), .b_o (b),
    .bank_req_o (bank_req), .bank_o (bank), .bank_gnt_i (bank_gnt),
    .bank_rvalid_i (bank_rvalid), .bank_rdata_i (bank_rdata)
  );

  always #50 clk_i = ~clk_i;

  task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED time=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_counts();
    $display("Errors: %0d check, %0d assertion; %0d R beats, %0d B responses",
             errors, u_axi_mem_top.u_axi_mem_sva.assert_fails, r_beats, b_seen);
  endtask

  task automatic load_trace(output bit ok);
    int    fd, n;
    string line, op;
    ok = 1'b0;
    fd = $fopen("sim/axi_mem_trace.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd) && n_lines < MAX_LINES) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 1 && line[0] != "#") begin
          op = "";
          n = $sscanf(line, "%s %h %h %h %h %h", op, tr_id[n_lines], tr_addr[n_lines],
                      tr_len[n_lines], tr_data[n_lines], tr_strb[n_lines]);
          if (op == "W" || op == "R" || op == "S") begin
            tr_op[n_lines] = op;
            if (op != "S") total_beats += int'(tr_len[n_lines]) + 1;
            n_lines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Bank model grants after 0 to 2 cycles and answers in the next cycle
  task automatic serve_bank(int i);
    int a;
    a = int'(bank[i].addr);
    for (int j = 0; j < BANK_BYTES; j++) begin
      bank_rdata[i][8*j +: 8] <= bank_mem[i][a+j];
      if (bank[i].we && bank[i].strb[j]) begin
        bank_mem[i][a+j] <= bank[i].wdata[8*j +: 8];
      end
    end
  endtask

  always @(posedge clk_i) begin
    for (int i = 0; i < NB; i++) begin
      if (!rst_ni) begin
        wait_cnt[i] = 0;
        bank_gnt[i]    <= 1'b1;
        bank_rvalid[i] <= 1'b0;
      end else begin
        bank_rvalid[i] <= bank_req[i] && bank_gnt[i];
        if (bank_req[i] && bank_gnt[i]) begin
          serve_bank(i);
          wait_cnt[i] = $urandom % 3;
        end else if (wait_cnt[i] != 0) begin
          wait_cnt[i] = wait_cnt[i] - 1;
        end
        bank_gnt[i] <= (wait_cnt[i] == 0);
      end
    end
  end

  always @(posedge clk_i) begin
    r_ready <= ($urandom % 4) != 0;  // Random stalls on R and B
    b_ready <= ($urandom % 3) != 0;
  end

  always @(posedge clk_i) begin
    if (rst_ni && r_valid && r_ready) begin
      if (exp_r.size() == 0) begin
        errors++;
        $display("Unexpected R beat at time %0t", $time);
      end else begin
        exp_beat = exp_r.pop_front();
        compare("r_data", r.data, exp_beat.data);
        compare("r_id", 32'(r.id), 32'(exp_beat.id));
        compare("r_last", 32'(r.last), 32'(exp_beat.last));
      end
      r_beats++;
    end
    if (rst_ni && b_valid && b_ready) begin
      if (exp_b.size() == 0 || b_seen >= writes_done) begin
        errors++;
        $display("B response at time %0t before its write burst was fully taken", $time);
      end else begin
        compare("b_id", 32'(b.id), 32'(exp_b.pop_front()));
      end
      b_seen++;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles with responses still missing", cycles);
      report_counts();
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic send_write(int i);
    int k;
    exp_b.push_back(id_t'(tr_id[i]));
    @(posedge clk_i);
    aw_valid <= 1'b1;
    aw <= '{addr: addr_t'(tr_addr[i]), id: id_t'(tr_id[i]), len: len_t'(tr_len[i]), size: 3'd2};
    w_valid <= 1'b1;
    w <= '{data: tr_data[i], strb: strb_t'(tr_strb[i]), last: (tr_len[i] == 0)};
    k = 0;
    while (k <= int'(tr_len[i])) begin
      @(posedge clk_i);
      if (aw_ready) aw_valid <= 1'b0;
      if (w_ready) begin
        k++;
        if (k <= int'(tr_len[i])) begin
          w <= '{data: tr_data[i] + 32'(k), strb: strb_t'(tr_strb[i]), last: (k == tr_len[i])};
        end else begin
          w_valid <= 1'b0;
        end
      end
    end
    writes_done++;
  endtask

  task automatic send_read(int i);
    bit first;
    for (int k = 0; k <= int'(tr_len[i]); k++) begin
      exp_r.push_back('{data: tr_data[i] + 32'(k), id: id_t'(tr_id[i]), last: (k == tr_len[i])});
    end
    @(posedge clk_i);
    ar_valid <= 1'b1;
    ar <= '{addr: addr_t'(tr_addr[i]), id: id_t'(tr_id[i]), len: len_t'(tr_len[i]), size: 3'd2};
    first = 1'b1;
    do begin
      @(posedge clk_i);
      if (first) compare("busy_o", 32'(busy), 32'd1);
      first = 1'b0;
    end while (!ar_ready);
    ar_valid <= 1'b0;
    if (tr_len[i] != 0) begin
      @(posedge clk_i);
      compare("busy_o", 32'(busy), 32'd1);  // Later beats still pending
    end
  endtask

  // Reads and writes of one segment start together
  task automatic run_segment(int lo, int hi);
    fork
      for (int i = lo; i <= hi; i++) if (tr_op[i] == "W") send_write(i);
      for (int i = lo; i <= hi; i++) if (tr_op[i] == "R") send_read(i);
    join
    do @(posedge clk_i); while (exp_r.size() != 0 || exp_b.size() != 0);
  endtask

  initial begin
    int lo;
    void'($urandom(32'hb27bd26f));  // Seed once
    clk_i = 1'b0;
    rst_ni = 1'b0;
    {ar_valid, aw_valid, w_valid, r_ready, b_ready} = '0;
    {ar, aw, w} = '0;
    {bank_gnt, bank_rvalid, bank_rdata} = '0;
    {n_lines, total_beats, errors, r_beats, b_seen, writes_done, cycles} = '0;
    cycle_limit = 100000;
    load_trace(trace_ok);
    if (!trace_ok || total_beats == 0) begin
      errors++;
      $display("Could not read any bursts from sim/axi_mem_trace.txt");
    end else begin
      cycle_limit = 200 * total_beats;
      repeat (2) @(posedge clk_i);
      rst_ni <= 1'b1;
      @(posedge clk_i);
      compare("busy_o", 32'(busy), 32'd0);
      lo = 0;
      for (int i = 0; i < n_lines; i++) begin
        if (tr_op[i] == "S" || i == n_lines - 1) begin
          run_segment(lo, i);
          lo = i + 1;
        end
      end
      @(posedge clk_i);
      compare("busy_o", 32'(busy), 32'd0);  // Idle after the final response
    end
    report_counts();
    if (errors == 0 && u_axi_mem_top.u_axi_mem_sva.assert_fails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
